// File: build.f
dmaPkg.sv
dmaBusDecode.sv
dmaChannelRegs.sv
dmaControlRegs.sv
dmaArbiter.sv
dmaReadMux.sv
dmaTop.sv
tbDma.sv

// File: dmaArbiter.sv
module dmaArbiter (
        input  dmaPkg::chanVec dreq,
        input  dmaPkg::chanVec swRequest,
        input  dmaPkg::chanVec mask,
        input  logic           disabled,
        input  dmaPkg::chanVec countZero,
        input  dmaPkg::dmaWord curAddr [dmaPkg::NumChannels],
        input  logic           xferReady,
        output logic           xferValid,
        output dmaPkg::chanIdx xferChannel,
        output dmaPkg::dmaWord xferAddr,
        output logic           xferLast,
        output logic           xferFire
);
        import dmaPkg::*;

        chanVec ready;

        assign ready = (dreq | swRequest) & ~mask & {NumChannels{!disabled}};

        // scan from the top so the lowest ready channel is left standing
        always_comb
        begin
                xferChannel = '0;
                for (int i = NumChannels - 1; i >= 0; i--)
                begin
                        if (ready[i])
                                xferChannel = chanIdx'(i);
                end
        end

        assign xferValid = |ready;
        assign xferAddr  = curAddr[xferChannel];
        assign xferLast  = countZero[xferChannel];
        assign xferFire  = xferValid && xferReady;

endmodule

// File: dmaBusDecode.sv
module dmaBusDecode (
        input  logic             dma_if,
        input  logic             arstN,
        input  logic             csN,
        input  logic             iorN,
        input  logic             iowN,
        input  dmaPkg::regOffset addr,
        output logic             chanWr,
        output logic             chanRd,
        output dmaPkg::chanIdx   chanSel,
        output logic             countSel,
        output logic             highByte,
        output logic             cmdWr,
        output logic             reqWr,
        output logic             singleMaskWr,
        output logic             modeWr,
        output logic             clearMask,
        output logic             allMaskWr,
        output logic             statusRd,
        output logic             masterClear
);
        import dmaPkg::*;

        logic wrCycle;
        logic rdCycle;
        logic chanAccess;
        logic clearPtr;
        logic masterClearWr;

        // write needs iorN high, a read wins if both strobes are low
        assign wrCycle = !csN && !iowN && iorN;
        assign rdCycle = !csN && !iorN;

        always_comb
        begin
                case (addr)
                        OffAddr0, OffCount0, OffAddr1, OffCount1,
                        OffAddr2, OffCount2, OffAddr3, OffCount3:
                                chanAccess = 1'b1;
                        default:
                                chanAccess = 1'b0;
                endcase
        end

        // channel offsets pair address and count per channel
        assign chanSel  = addr[2:1];
        assign countSel = addr[0];

        assign chanWr       = wrCycle && chanAccess;
        assign chanRd       = rdCycle && chanAccess;
        assign cmdWr        = wrCycle && (addr == OffCommand);
        assign reqWr        = wrCycle && (addr == OffRequest);
        assign singleMaskWr = wrCycle && (addr == OffSingleMask);
        assign modeWr       = wrCycle && (addr == OffMode);
        assign clearPtr     = wrCycle && (addr == OffClearPtr);
        assign masterClearWr = wrCycle && (addr == OffMasterClear);
        assign clearMask    = wrCycle && (addr == OffClearMask);
        assign allMaskWr    = wrCycle && (addr == OffAllMask);
        assign statusRd     = rdCycle && (addr == OffCommand);

        // byte pointer flips on every channel access, low byte first
        always_ff @(posedge dma_if or negedge arstN)
        begin
                if (!arstN)
                begin
                        highByte    <= 1'b0;
                        masterClear <= 1'b0;
                end
                else
                begin
                        masterClear <= masterClearWr;
                        if (masterClear || clearPtr)
                                highByte <= 1'b0;
                        else if (chanWr || chanRd)
                                highByte <= !highByte;
                end
        end

endmodule

// File: dmaChannelRegs.sv
module dmaChannelRegs (
        input  logic           dma_if,
        input  logic           arstN,
        input  logic           masterClear,
        input  logic           chanWr,
        input  dmaPkg::chanIdx chanSel,
        input  logic           countSel,
        input  logic           highByte,
        input  dmaPkg::dmaByte dataIn,
        input  logic           xferFire,
        input  dmaPkg::chanIdx xferChannel,
        input  dmaPkg::chanVec autoInit,
        input  dmaPkg::chanVec decrement,
        output dmaPkg::dmaWord curAddr [dmaPkg::NumChannels],
        output dmaPkg::dmaWord curCount [dmaPkg::NumChannels],
        output dmaPkg::chanVec countZero,
        output dmaPkg::chanVec tcEvent
);
        import dmaPkg::*;

        dmaWord baseAddr [NumChannels];
        dmaWord baseCount [NumChannels];
        dmaWord stepAddr;

        assign stepAddr = decrement[xferChannel] ? curAddr[xferChannel] - 16'd1
                                                 : curAddr[xferChannel] + 16'd1;

        always_ff @(posedge dma_if or negedge arstN)
        begin
                if (!arstN)
                begin
                        for (int i = 0; i < NumChannels; i++)
                        begin
                                baseAddr[i]  <= '0;
                                baseCount[i] <= '0;
                                curAddr[i]   <= '0;
                                curCount[i]  <= '0;
                        end
                end
                else if (masterClear)
                begin
                        for (int i = 0; i < NumChannels; i++)
                        begin
                                baseAddr[i]  <= '0;
                                baseCount[i] <= '0;
                                curAddr[i]   <= '0;
                                curCount[i]  <= '0;
                        end
                end
                else
                begin
                        if (xferFire)
                        begin
                                if (!countZero[xferChannel])
                                begin
                                        curAddr[xferChannel]  <= stepAddr;
                                        curCount[xferChannel] <= curCount[xferChannel] - 16'd1;
                                end
                                else if (autoInit[xferChannel])
                                begin
                                        curAddr[xferChannel]  <= baseAddr[xferChannel];
                                        curCount[xferChannel] <= baseCount[xferChannel];
                                end
                                // single-shot channels keep their final values
                        end

                        // cpu byte goes to base and current copy, overriding a transfer step
                        if (chanWr)
                        begin
                                case ({countSel, highByte})
                                        2'b00:
                                        begin
                                                baseAddr[chanSel][7:0] <= dataIn;
                                                curAddr[chanSel][7:0]  <= dataIn;
                                        end
                                        2'b01:
                                        begin
                                                baseAddr[chanSel][15:8] <= dataIn;
                                                curAddr[chanSel][15:8]  <= dataIn;
                                        end
                                        2'b10:
                                        begin
                                                baseCount[chanSel][7:0] <= dataIn;
                                                curCount[chanSel][7:0]  <= dataIn;
                                        end
                                        default:
                                        begin
                                                baseCount[chanSel][15:8] <= dataIn;
                                                curCount[chanSel][15:8]  <= dataIn;
                                        end
                                endcase
                        end
                end
        end

        // terminal count is the transfer that fires with a zero count
        always_comb
        begin
                for (int i = 0; i < NumChannels; i++)
                begin
                        countZero[i] = (curCount[i] == '0);
                        tcEvent[i]   = xferFire && (xferChannel == i) && countZero[i];
                end
        end

endmodule

// File: dmaControlRegs.sv
module dmaControlRegs (
        input  logic           dma_if,
        input  logic           arstN,
        input  logic           masterClear,
        input  dmaPkg::dmaByte dataIn,
        input  logic           cmdWr,
        input  logic           reqWr,
        input  logic           singleMaskWr,
        input  logic           modeWr,
        input  logic           clearMask,
        input  logic           allMaskWr,
        input  logic           statusRd,
        input  dmaPkg::chanVec tcEvent,
        output logic           disabled,
        output dmaPkg::chanVec autoInit,
        output dmaPkg::chanVec decrement,
        output dmaPkg::chanVec swRequest,
        output dmaPkg::chanVec mask,
        output dmaPkg::chanVec tcStatus
);
        import dmaPkg::*;

        chanIdx byteChan;

        // mode, request and single-mask bytes carry the channel in bits 1..0
        assign byteChan = dataIn[1:0];

        always_ff @(posedge dma_if or negedge arstN)
        begin
                if (!arstN)
                begin
                        disabled  <= 1'b0;
                        autoInit  <= '0;
                        decrement <= '0;
                        swRequest <= '0;
                        mask      <= '0;
                        tcStatus  <= '0;
                end
                else if (masterClear)
                begin
                        disabled  <= 1'b0;
                        autoInit  <= '0;
                        decrement <= '0;
                        swRequest <= '0;
                        mask      <= '0;
                        tcStatus  <= '0;
                end
                else
                begin
                        // end of block drops the request, single-shot channels mask themselves
                        swRequest <= swRequest & ~tcEvent;
                        mask      <= mask | (tcEvent & ~autoInit);

                        // a tc landing on the read edge survives for the next read
                        tcStatus <= (statusRd ? '0 : tcStatus) | tcEvent;

                        if (cmdWr)
                                disabled <= dataIn[CmdDisableBit];
                        if (modeWr)
                        begin
                                autoInit[byteChan]  <= dataIn[ModeAutoInitBit];
                                decrement[byteChan] <= dataIn[ModeDecrementBit];
                        end
                        if (reqWr)
                                swRequest[byteChan] <= dataIn[ReqSetBit];
                        if (singleMaskWr)
                                mask[byteChan] <= dataIn[ReqSetBit];
                        if (clearMask)
                                mask <= '0;
                        if (allMaskWr)
                                mask <= dataIn[NumChannels-1:0];
                end
        end

endmodule

// File: dmaPkg.sv
package dmaPkg;

        localparam int NumChannels = 4;

        // cpu data byte and the 16-bit address/count word
        typedef logic [7:0]  dmaByte;
        typedef logic [15:0] dmaWord;

        // channel number and one flag per channel
        typedef logic [1:0]  chanIdx;
        typedef logic [3:0]  chanVec;

        // port offsets, channel registers sit at 0..7 as address/count pairs
        typedef enum logic [3:0] {
                OffAddr0       = 4'h0,
                OffCount0      = 4'h1,
                OffAddr1       = 4'h2,
                OffCount1      = 4'h3,
                OffAddr2       = 4'h4,
                OffCount2      = 4'h5,
                OffAddr3       = 4'h6,
                OffCount3      = 4'h7,
                OffCommand     = 4'h8,
                OffRequest     = 4'h9,
                OffSingleMask  = 4'hA,
                OffMode        = 4'hB,
                OffClearPtr    = 4'hC,
                OffMasterClear = 4'hD,
                OffClearMask   = 4'hE,
                OffAllMask     = 4'hF
        } regOffset;

        // mode byte fields, channel number is always in bits 1..0
        localparam int ModeAutoInitBit  = 4;
        localparam int ModeDecrementBit = 5;

        // set/clear bit shared by request and single-mask writes
        localparam int ReqSetBit = 2;

        // command byte
        localparam int CmdDisableBit = 2;

endpackage

// File: dmaReadMux.sv
module dmaReadMux (
        input  logic           dma_if,
        input  logic           arstN,
        input  logic           chanRd,
        input  dmaPkg::chanIdx chanSel,
        input  logic           countSel,
        input  logic           highByte,
        input  logic           statusRd,
        input  dmaPkg::dmaWord curAddr [dmaPkg::NumChannels],
        input  dmaPkg::dmaWord curCount [dmaPkg::NumChannels],
        input  dmaPkg::chanVec tcStatus,
        input  dmaPkg::chanVec dreq,
        input  dmaPkg::chanVec swRequest,
        output dmaPkg::dmaByte dataOut
);
        import dmaPkg::*;

        dmaWord selWord;

        assign selWord = countSel ? curCount[chanSel] : curAddr[chanSel];

        // dataOut holds between reads, master clear leaves it alone
        always_ff @(posedge dma_if or negedge arstN)
        begin
                if (!arstN)
                        dataOut <= '0;
                else if (chanRd)
                        dataOut <= highByte ? selWord[15:8] : selWord[7:0];
                else if (statusRd)
                        dataOut <= {dreq | swRequest, tcStatus};
        end

endmodule

// File: dmaTop.sv
module dmaTop (
        input  logic             dma_if,
        input  logic             arstN,
        input  logic             csN,
        input  logic             iorN,
        input  logic             iowN,
        input  dmaPkg::regOffset addr,
        input  dmaPkg::dmaByte   dataIn,
        output dmaPkg::dmaByte   dataOut,
        input  dmaPkg::chanVec   dreq,
        input  logic             xferReady,
        output logic             xferValid,
        output dmaPkg::chanIdx   xferChannel,
        output dmaPkg::dmaWord   xferAddr,
        output logic             xferLast
);
        import dmaPkg::*;

        logic   chanWr;
        logic   chanRd;
        chanIdx chanSel;
        logic   countSel;
        logic   highByte;
        logic   cmdWr;
        logic   reqWr;
        logic   singleMaskWr;
        logic   modeWr;
        logic   clearMask;
        logic   allMaskWr;
        logic   statusRd;
        logic   masterClear;
        logic   xferFire;
        logic   disabled;
        chanVec autoInit;
        chanVec decrement;
        chanVec swRequest;
        chanVec mask;
        chanVec tcStatus;
        chanVec countZero;
        chanVec tcEvent;
        dmaWord curAddr [NumChannels];
        dmaWord curCount [NumChannels];

        dmaBusDecode busDecode (
                .dma_if, .arstN, .csN, .iorN, .iowN, .addr,
                .chanWr, .chanRd, .chanSel, .countSel, .highByte,
                .cmdWr, .reqWr, .singleMaskWr, .modeWr, .clearMask,
                .allMaskWr, .statusRd, .masterClear
        );

        dmaChannelRegs channelRegs (
                .dma_if, .arstN, .masterClear, .chanWr, .chanSel, .countSel,
                .highByte, .dataIn, .xferFire, .xferChannel, .autoInit,
                .decrement, .curAddr, .curCount, .countZero, .tcEvent
        );

        dmaControlRegs controlRegs (
                .dma_if, .arstN, .masterClear, .dataIn, .cmdWr, .reqWr,
                .singleMaskWr, .modeWr, .clearMask, .allMaskWr, .statusRd,
                .tcEvent, .disabled, .autoInit, .decrement, .swRequest,
                .mask, .tcStatus
        );

        dmaArbiter arbiter (
                .dreq, .swRequest, .mask, .disabled, .countZero, .curAddr,
                .xferReady, .xferValid, .xferChannel, .xferAddr, .xferLast,
                .xferFire
        );

        dmaReadMux readMux (
                .dma_if, .arstN, .chanRd, .chanSel, .countSel, .highByte,
                .statusRd, .curAddr, .curCount, .tcStatus, .dreq, .swRequest,
                .dataOut
        );

endmodule

// File: tbDma.sv
module tbDma;
        timeunit 1ns;
        timeprecision 100ps;

        import dmaPkg::*;

        localparam int WaitLimit = 50;

        logic        dma_if;
        logic        arstN;
        logic        csN;
        logic        iorN;
        logic        iowN;
        regOffset    addr;
        dmaByte      dataIn;
        dmaByte      dataOut;
        chanVec      dreq;
        logic        xferReady;
        logic        xferValid;
        chanIdx      xferChannel;
        dmaWord      xferAddr;
        logic        xferLast;
        int          errors;
        int          checks;
        int unsigned lcgState;

        dmaTop UUT (
                .dma_if, .arstN, .csN, .iorN, .iowN, .addr, .dataIn, .dataOut,
                .dreq, .xferReady, .xferValid, .xferChannel, .xferAddr, .xferLast
        );

        always #5 dma_if = !dma_if;

        function automatic int unsigned lcgNext();
                lcgState = lcgState * 32'd1664525 + 32'd1013904223;
                return lcgState >> 8;
        endfunction

        // channel registers sit in address/count pairs
        function automatic regOffset addrOff(input chanIdx ch);
                return regOffset'({1'b0, ch, 1'b0});
        endfunction

        function automatic regOffset countOff(input chanIdx ch);
                return regOffset'({1'b0, ch, 1'b1});
        endfunction

        task automatic checkByte(input string name, input dmaByte expected, input dmaByte actual);
                checks++;
                if (actual !== expected)
                begin
                        errors++;
                        $display("CHECK FAILED at %0t: %s expected %h, got %h",
                                 $time, name, expected, actual);
                end
        endtask

        task automatic checkWord(input string name, input dmaWord expected, input dmaWord actual);
                checks++;
                if (actual !== expected)
                begin
                        errors++;
                        $display("CHECK FAILED at %0t: %s expected %h, got %h",
                                 $time, name, expected, actual);
                end
        endtask

        task automatic checkChan(input string name, input chanIdx expected, input chanIdx actual);
                checks++;
                if (actual !== expected)
                begin
                        errors++;
                        $display("CHECK FAILED at %0t: %s expected %0d, got %0d",
                                 $time, name, expected, actual);
                end
        endtask

        task automatic checkBit(input string name, input logic expected, input logic actual);
                checks++;
                if (actual !== expected)
                begin
                        errors++;
                        $display("CHECK FAILED at %0t: %s expected %b, got %b",
                                 $time, name, expected, actual);
                end
        endtask

        // bus tasks start and end 1 ns after a rising edge
        task automatic cpuWrite(input regOffset off, input dmaByte data);
                csN    = 1'b0;
                iowN   = 1'b0;
                addr   = off;
                dataIn = data;
                @(posedge dma_if);
                #1;
                csN  = 1'b1;
                iowN = 1'b1;
        endtask

        task automatic cpuRead(input regOffset off, output dmaByte data);
                csN  = 1'b0;
                iorN = 1'b0;
                addr = off;
                @(posedge dma_if);
                #1;
                csN  = 1'b1;
                iorN = 1'b1;
                data = dataOut;
        endtask

        task automatic writeWord(input regOffset off, input dmaWord value);
                cpuWrite(off, value[7:0]);
                cpuWrite(off, value[15:8]);
        endtask

        task automatic readWord(input regOffset off, output dmaWord value);
                dmaByte lo;
                dmaByte hi;
                cpuRead(off, lo);
                cpuRead(off, hi);
                value = {hi, lo};
        endtask

        task automatic watchValid(input logic expValid, input int cycles);
                repeat (cycles)
                begin
                        @(negedge dma_if);
                        checkBit("xferValid", expValid, xferValid);
                        @(posedge dma_if);
                        #1;
                end
        endtask

        // acts as the memory side and tracks the expected address and count
        task automatic serviceTransfers(input chanIdx ch, input dmaWord startAddr,
                                        input dmaWord startCount, input logic down,
                                        input logic autoReload, input int numXfers,
                                        input logic stall);
                dmaWord expAddr;
                dmaWord expCount;
                int     waited;
                int     stalls;
                expAddr  = startAddr;
                expCount = startCount;
                for (int k = 0; k < numXfers; k++)
                begin
                        waited = 0;
                        @(negedge dma_if);
                        while (!xferValid && waited < WaitLimit)
                        begin
                                @(negedge dma_if);
                                waited++;
                        end
                        if (!xferValid)
                        begin
                                errors++;
                                $display("Timed out at %0t waiting for a transfer on channel %0d",
                                         $time, ch);
                                @(posedge dma_if);
                                #1;
                                return;
                        end
                        checkChan("xferChannel", ch, xferChannel);
                        checkWord("xferAddr", expAddr, xferAddr);
                        checkBit("xferLast", expCount == 0, xferLast);
                        stalls = stall ? int'(lcgNext() % 3) : 0;
                        // the presented transfer must not move while ready is low
                        repeat (stalls)
                        begin
                                @(negedge dma_if);
                                checkChan("xferChannel", ch, xferChannel);
                                checkWord("xferAddr", expAddr, xferAddr);
                        end
                        @(posedge dma_if);
                        #1;
                        xferReady = 1'b1;
                        @(negedge dma_if);
                        checkBit("xferValid", 1'b1, xferValid);
                        checkWord("xferAddr", expAddr, xferAddr);
                        @(posedge dma_if);
                        #1;
                        xferReady = 1'b0;
                        if (expCount != 0)
                        begin
                                expAddr  = down ? expAddr - 16'd1 : expAddr + 16'd1;
                                expCount = expCount - 16'd1;
                        end
                        else if (autoReload)
                        begin
                                expAddr  = startAddr;
                                expCount = startCount;
                        end
                end
        endtask

        task automatic resetTest();
                dmaByte status;
                dmaWord value;
                watchValid(1'b0, 1);
                cpuRead(OffCommand, status);
                checkByte("status", 8'h00, status);
                for (int c = 0; c < NumChannels; c++)
                begin
                        readWord(addrOff(chanIdx'(c)), value);
                        checkWord($sformatf("curAddr[%0d]", c), 16'h0000, value);
                        readWord(countOff(chanIdx'(c)), value);
                        checkWord($sformatf("curCount[%0d]", c), 16'h0000, value);
                end
        endtask

        task automatic bytePointerTest();
                dmaWord addrVals [NumChannels];
                dmaWord countVals [NumChannels];
                dmaWord value;
                dmaWord readBack;
                dmaByte lowByte;
                for (int c = 0; c < NumChannels; c++)
                begin
                        addrVals[c]  = dmaWord'(lcgNext());
                        countVals[c] = dmaWord'(lcgNext());
                        writeWord(addrOff(chanIdx'(c)), addrVals[c]);
                        writeWord(countOff(chanIdx'(c)), countVals[c]);
                end
                for (int c = 0; c < NumChannels; c++)
                begin
                        readWord(addrOff(chanIdx'(c)), readBack);
                        checkWord($sformatf("curAddr[%0d]", c), addrVals[c], readBack);
                        readWord(countOff(chanIdx'(c)), readBack);
                        checkWord($sformatf("curCount[%0d]", c), countVals[c], readBack);
                end
                // half-written pair abandoned by clear byte pointer
                value = dmaWord'(lcgNext());
                cpuWrite(OffAddr2, 8'hA5);
                cpuWrite(OffClearPtr, 8'h00);
                writeWord(OffAddr2, value);
                cpuRead(OffAddr2, lowByte);
                checkByte("dataOut", value[7:0], lowByte);
                cpuWrite(OffClearPtr, 8'h00);
                readWord(OffAddr2, readBack);
                checkWord("curAddr[2]", value, readBack);
        endtask

        task automatic incrementTest();
                dmaWord startAddr;
                dmaWord count;
                dmaWord value;
                dmaByte status;
                startAddr = dmaWord'(lcgNext());
                count     = dmaWord'(2 + lcgNext() % 4);
                cpuWrite(OffMode, 8'h01);
                writeWord(OffAddr1, startAddr);
                writeWord(OffCount1, count);
                cpuWrite(OffRequest, 8'h05);
                serviceTransfers(2'd1, startAddr, count, 1'b0, 1'b0, count + 1, 1'b1);
                watchValid(1'b0, 2);
                cpuRead(OffCommand, status);
                checkByte("status", 8'h02, status);
                cpuRead(OffCommand, status);
                checkByte("status", 8'h00, status);
                // single shot leaves the final address and a zero count
                readWord(OffAddr1, value);
                checkWord("curAddr[1]", startAddr + count, value);
                readWord(OffCount1, value);
                checkWord("curCount[1]", 16'h0000, value);
                dreq[1] = 1'b1;
                watchValid(1'b0, 6);
                cpuRead(OffCommand, status);
                checkByte("status", 8'h20, status);
                dreq[1] = 1'b0;
        endtask

        task automatic decrementAutoInitTest();
                dmaWord startAddr;
                dmaWord count;
                dmaWord value;
                dmaByte status;
                startAddr = dmaWord'(lcgNext());
                count     = dmaWord'(2 + lcgNext() % 4);
                cpuWrite(OffMode, 8'h32);
                writeWord(OffAddr2, startAddr);
                writeWord(OffCount2, count);
                cpuWrite(OffRequest, 8'h06);
                serviceTransfers(2'd2, startAddr, count, 1'b1, 1'b1, count + 1, 1'b1);
                watchValid(1'b0, 2);
                readWord(OffAddr2, value);
                checkWord("curAddr[2]", startAddr, value);
                readWord(OffCount2, value);
                checkWord("curCount[2]", count, value);
                cpuRead(OffCommand, status);
                checkByte("status", 8'h04, status);
                // still unmasked after reload
                dreq[2] = 1'b1;
                serviceTransfers(2'd2, startAddr, count, 1'b1, 1'b1, 2, 1'b0);
                dreq[2] = 1'b0;
                watchValid(1'b0, 1);
        endtask

        task automatic priorityTest();
                dmaWord addrB;
                dmaWord addrC;
                dmaWord addrD;
                addrB = dmaWord'(lcgNext());
                addrC = dmaWord'(lcgNext());
                addrD = dmaWord'(lcgNext());
                cpuWrite(OffClearMask, 8'h00);
                cpuWrite(OffMode, 8'h02);
                cpuWrite(OffMode, 8'h03);
                writeWord(OffAddr2, addrB);
                writeWord(OffCount2, 16'd1);
                writeWord(OffAddr3, addrC);
                writeWord(OffCount3, 16'd1);
                dreq = 4'b1100;
                serviceTransfers(2'd2, addrB, 16'd1, 1'b0, 1'b0, 2, 1'b1);
                serviceTransfers(2'd3, addrC, 16'd1, 1'b0, 1'b0, 2, 1'b1);
                dreq = 4'b0000;
                watchValid(1'b0, 2);
                // channel 1 wins because channel 0 is masked
                cpuWrite(OffSingleMask, 8'h04);
                writeWord(OffAddr1, addrD);
                writeWord(OffCount1, 16'd0);
                dreq = 4'b0011;
                serviceTransfers(2'd1, addrD, 16'd0, 1'b0, 1'b0, 1, 1'b1);
                watchValid(1'b0, 4);
                cpuWrite(OffClearMask, 8'h00);
                watchValid(1'b1, 1);
                cpuWrite(OffCommand, 8'h04);
                watchValid(1'b0, 4);
                dreq = 4'b0000;
        endtask

        task automatic masterClearTest();
                dmaByte status;
                dmaWord value;
                dmaWord readBack;
                cpuWrite(OffAllMask, 8'h0F);
                cpuWrite(OffMode, 8'h33);
                // odd byte count leaves the pointer on the high byte
                cpuWrite(OffAddr0, 8'h5A);
                cpuWrite(OffMasterClear, 8'h00);
                watchValid(1'b0, 1);
                cpuRead(OffCommand, status);
                checkByte("status", 8'h00, status);
                for (int c = 0; c < NumChannels; c++)
                begin
                        readWord(addrOff(chanIdx'(c)), readBack);
                        checkWord($sformatf("curAddr[%0d]", c), 16'h0000, readBack);
                        readWord(countOff(chanIdx'(c)), readBack);
                        checkWord($sformatf("curCount[%0d]", c), 16'h0000, readBack);
                end
                // written from the pointer left by master clear, read back from the low byte
                value = dmaWord'(lcgNext());
                writeWord(OffAddr0, value);
                cpuWrite(OffClearPtr, 8'h00);
                readWord(OffAddr0, readBack);
                checkWord("curAddr[0]", value, readBack);
                dreq = 4'b1000;
                @(negedge dma_if);
                checkBit("xferValid", 1'b1, xferValid);
                checkChan("xferChannel", 2'd3, xferChannel);
                @(posedge dma_if);
                #1;
                dreq = 4'b0000;
        endtask

        initial
        begin
                dma_if    = 1'b0;
                arstN     = 1'b0;
                csN       = 1'b1;
                iorN      = 1'b1;
                iowN      = 1'b1;
                addr      = OffAddr0;
                dataIn    = '0;
                dreq      = '0;
                xferReady = 1'b0;
                lcgState  = 14;
                errors    = 0;
                checks    = 0;
                repeat (4) @(posedge dma_if);
                #1;
                arstN = 1'b1;
                resetTest();
                bytePointerTest();
                incrementTest();
                decrementAutoInitTest();
                priorityTest();
                masterClearTest();
                $display("checks run: %0d, errors: %0d", checks, errors);
                if (errors == 0)
                        $display("Simulation finished: PASS");
                else
                        $display("Simulation finished: FAIL");
                $finish;
        end

endmodule
